/* Makefile */
VERILATOR  ?= verilator
VFLAGS     = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing
TOP        = tb_spi_memory
FLIST      = flist.f
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_TEXT  = Simulation passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# the run passes only if the log holds the pass line
sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* flist.f */
hw/spi_mem_pkg.sv
hw/spi_input_sync.sv
hw/spi_shift_register.sv
hw/spi_data_memory.sv
hw/spi_fsm.sv
hw/spi_memory.sv
sim/tb_spi_memory.sv

/* hw/spi_data_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_data_memory
    import spi_mem_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      addr_we,
    input  spi_cmd_u                  cmd,
    input  logic                      dm_we,
    input  logic [spi_data_width-1:0] wdata,
    output logic [spi_data_width-1:0] rdata
);

    logic [spi_addr_width-1:0] addr_q;
    logic [spi_data_width-1:0] mem [spi_mem_depth];

    // address latch and storage clear on reset so unwritten bytes read as zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_q <= '0;
            for (int i = 0; i < spi_mem_depth; i++) begin
                mem[i] <= '0;
            end
        end else begin
            if (addr_we) begin
                addr_q <= cmd.f.addr;
            end
            if (dm_we) begin
                mem[addr_q] <= wdata;
            end
        end
    end

    // read port follows the latched address with one clock of latency
    always_ff @(posedge clk) begin
        rdata <= mem[addr_q];
    end

    // a write never lands in the cycle of the address latch or the one after
    addr_before_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        addr_we |-> !dm_we ##1 !dm_we
    ) else $error("memory write too close to address latch");

endmodule

`default_nettype wire

/* hw/spi_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_fsm
    import spi_mem_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     cs_active,
    input  logic     sclk_rise,
    input  logic     sclk_fall,
    input  spi_cmd_u cmd,
    output logic     addr_we,
    output logic     dm_we,
    output logic     sr_load,
    output logic     sr_shift,
    output logic     out_advance,
    output logic     miso_oe
);

    localparam logic [3:0] byte_bits = 4'(spi_data_width);
    localparam logic [3:0] last_bit  = byte_bits - 4'd1;

    spi_state_e state;
    logic [3:0] bit_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= idle;
            bit_cnt <= '0;
        end else if (!cs_active) begin
            // deselect aborts whatever is in flight
            state   <= idle;
            bit_cnt <= '0;
        end else begin
            case (state)
                idle: begin
                    state   <= addr_load;
                    bit_cnt <= '0;
                end
                addr_load: begin
                    if (sclk_rise) begin
                        if (bit_cnt == last_bit) begin
                            state   <= branch;
                            bit_cnt <= '0;
                        end else begin
                            bit_cnt <= bit_cnt + 4'd1;
                        end
                    end
                end
                branch: begin
                    state <= cmd.f.rw ? read_load : write_data;
                end
                write_data: begin
                    if (sclk_rise) begin
                        if (bit_cnt == last_bit) begin
                            state   <= store;
                            bit_cnt <= '0;
                        end else begin
                            bit_cnt <= bit_cnt + 4'd1;
                        end
                    end
                end
                store: begin
                    state <= done;
                end
                read_load: begin
                    // first cycle waits for the registered read data
                    if (bit_cnt == 4'd0) begin
                        bit_cnt <= 4'd1;
                    end else begin
                        state   <= read_shift;
                        bit_cnt <= '0;
                    end
                end
                read_shift: begin
                    // counts data rises; the last address fall arrives with bit_cnt at 0
                    if (sclk_rise) begin
                        bit_cnt <= bit_cnt + 4'd1;
                    end else if (sclk_fall && bit_cnt == byte_bits) begin
                        state <= done;
                    end
                end
                done: begin
                    state <= done;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // enable table per state
    always_comb begin
        addr_we     = 1'b0;
        dm_we       = 1'b0;
        sr_load     = 1'b0;
        out_advance = 1'b0;
        miso_oe     = 1'b0;
        case (state)
            branch:     addr_we = 1'b1;
            store:      dm_we = 1'b1;
            read_load:  sr_load = (bit_cnt != 4'd0);
            read_shift: begin
                miso_oe     = 1'b1;
                out_advance = sclk_fall && (bit_cnt != 4'd0);
            end
            default: ;
        endcase
    end

    // shift register samples mosi on every selected rising edge
    assign sr_shift = cs_active & sclk_rise;

    // store is a one clock pulse and never overlaps the miso driver
    store_vs_drive: assert property (
        @(posedge clk) disable iff (!rst_n)
        dm_we |-> !miso_oe ##1 !dm_we
    ) else $error("dm_we overlaps miso_oe or lasts more than one clock");

endmodule

`default_nettype wire

/* hw/spi_input_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_input_sync #(
    parameter int SYNC_STAGES = 2
) (
    input  logic clk,
    input  logic rst_n,
    input  logic sclk,
    input  logic cs_n,
    input  logic mosi,
    output logic cs_active,
    output logic mosi_s,
    output logic sclk_rise,
    output logic sclk_fall
);

    // each stage holds sclk, cs_n and mosi from msb down
    // idle bus has sclk low and cs_n high
    localparam logic [2:0] pin_idle = 3'b010;

    logic [2:0] pin_ff [SYNC_STAGES];
    logic       sclk_s;
    logic       sclk_prev;

    // one chain carries all three pins
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                pin_ff[i] <= pin_idle;
            end
        end else begin
            pin_ff[0] <= {sclk, cs_n, mosi};
            for (int i = 1; i < SYNC_STAGES; i++) begin
                pin_ff[i] <= pin_ff[i-1];
            end
        end
    end

    assign sclk_s    = pin_ff[SYNC_STAGES-1][2];
    assign cs_active = ~pin_ff[SYNC_STAGES-1][1];
    assign mosi_s    = pin_ff[SYNC_STAGES-1][0];

    // strobes are registered so they land
    // SYNC_STAGES + 1 clocks after the pin edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sclk_prev <= 1'b0;
            sclk_rise <= 1'b0;
            sclk_fall <= 1'b0;
        end else begin
            sclk_prev <= sclk_s;
            sclk_rise <= sclk_s & ~sclk_prev;
            sclk_fall <= ~sclk_s & sclk_prev;
        end
    end

    // strobes never overlap and each lasts a single clock
    strobe_single_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        (sclk_rise || sclk_fall) |-> !(sclk_rise && sclk_fall) ##1 !(sclk_rise || sclk_fall)
    ) else $error("sclk strobes overlap or last longer than one clock");

endmodule

`default_nettype wire

/* hw/spi_mem_pkg.sv */
`default_nettype none

package spi_mem_pkg;

    // command byte layout and memory size
    localparam int spi_addr_width = 7;
    localparam int spi_data_width = 8;
    localparam int spi_mem_depth  = 2 ** spi_addr_width;

    // the shift register treats the byte as raw bits
    // the fsm and the memory split it into address and rw flag
    typedef union packed {
        logic [spi_data_width-1:0] raw;
        struct packed {
            logic [spi_addr_width-1:0] addr;
            // 1 selects a read
            logic                      rw;
        } f;
    } spi_cmd_u;

    // transaction states
    typedef enum logic [2:0] {
        idle       = 3'd0,
        addr_load  = 3'd1,
        branch     = 3'd2,
        write_data = 3'd3,
        store      = 3'd4,
        read_load  = 3'd5,
        read_shift = 3'd6,
        done       = 3'd7
    } spi_state_e;

endpackage

`default_nettype wire

/* hw/spi_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_memory
    import spi_mem_pkg::*;
#(
    parameter int SYNC_STAGES = 2
) (
    input  logic clk,
    input  logic rst_n,
    input  logic sclk,
    input  logic cs_n,
    input  logic mosi,
    output logic miso,
    output logic miso_oe
);

    logic cs_active;
    logic mosi_s;
    logic sclk_rise;
    logic sclk_fall;

    logic addr_we;
    logic dm_we;
    logic sr_load;
    logic sr_shift;
    logic out_advance;

    // byte assembled from mosi and byte read from storage
    spi_cmd_u                  sr_byte;
    logic [spi_data_width-1:0] rd_byte;

    spi_input_sync #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_sync (
        .clk       (clk),
        .rst_n     (rst_n),
        .sclk      (sclk),
        .cs_n      (cs_n),
        .mosi      (mosi),
        .cs_active (cs_active),
        .mosi_s    (mosi_s),
        .sclk_rise (sclk_rise),
        .sclk_fall (sclk_fall)
    );

    spi_fsm u_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .cs_active   (cs_active),
        .sclk_rise   (sclk_rise),
        .sclk_fall   (sclk_fall),
        .cmd         (sr_byte),
        .addr_we     (addr_we),
        .dm_we       (dm_we),
        .sr_load     (sr_load),
        .sr_shift    (sr_shift),
        .out_advance (out_advance),
        .miso_oe     (miso_oe)
    );

    spi_shift_register u_shift (
        .clk          (clk),
        .rst_n        (rst_n),
        .shift_en     (sr_shift),
        .out_advance  (out_advance),
        .load_en      (sr_load),
        .serial_in    (mosi_s),
        .load_data    (spi_cmd_u'(rd_byte)),
        .parallel_out (sr_byte),
        .serial_out   (miso)
    );

    // the same byte carries the command in the address phase and the data later
    spi_data_memory u_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .addr_we (addr_we),
        .cmd     (sr_byte),
        .dm_we   (dm_we),
        .wdata   (sr_byte.raw),
        .rdata   (rd_byte)
    );

endmodule

`default_nettype wire

/* hw/spi_shift_register.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_shift_register
    import spi_mem_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     shift_en,
    input  logic     out_advance,
    input  logic     load_en,
    input  logic     serial_in,
    input  spi_cmd_u load_data,
    output spi_cmd_u parallel_out,
    output logic     serial_out
);

    spi_cmd_u shift_q;
    // bit currently presented on miso
    logic     miso_bit;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shift_q  <= '0;
            miso_bit <= 1'b0;
        end else if (load_en) begin
            // msb goes straight out so it is ready before the first data rise
            shift_q  <= load_data;
            miso_bit <= load_data.raw[spi_data_width-1];
        end else begin
            // sample on rising sclk with the msb arriving first
            if (shift_en) begin
                shift_q.raw <= {shift_q.raw[spi_data_width-2:0], serial_in};
            end
            // next bit moves to miso on falling sclk
            if (out_advance) begin
                miso_bit <= shift_q.raw[spi_data_width-1];
            end
        end
    end

    assign parallel_out = shift_q;
    assign serial_out   = miso_bit;

    // fsm must never load while a rising strobe is shifting
    load_vs_shift: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(load_en && shift_en)
    ) else $error("shift register load and shift in the same cycle");

endmodule

`default_nettype wire

/* sim/spi_cases.txt */
# op addr data, both hex; w writes, r reads and expects data
# a aborts a write after data rising edges, n runs data random operations
r 05 00
w 05 a5
r 05 a5
w 00 11
w 7f ee
w 01 22
w 7e dd
r 00 11
r 7f ee
r 01 22
r 7e dd
r 40 00
a 05 03
r 05 a5
a 05 0c
r 05 a5
a 7f 0f
r 7f ee
w 33 3c
r 33 3c
n 00 30

/* sim/tb_spi_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_spi_memory;

    localparam int          clk_period  = 40;
    // sclk half period in clk cycles
    localparam int          sclk_half   = 8;
    localparam int          sclk_period = 2 * sclk_half * clk_period;
    localparam logic [31:0] rng_seed    = 32'h921c_15dc;
    localparam              cases_file  = "sim/spi_cases.txt";
    localparam int          max_cases   = 64;

    logic clk;
    logic rst_n;
    logic sclk;
    logic cs_n;
    logic mosi;
    logic miso;
    logic miso_oe;

    // expected memory contents
    logic [7:0]  ref_mem [128];
    logic [31:0] rng_state;

    logic [7:0] case_op   [max_cases];
    logic [7:0] case_addr [max_cases];
    logic [7:0] case_data [max_cases];
    int         num_cases;
    int         test_errors;
    int         tests_run;
    int         tests_failed;
    int         total_errors;
    longint     watchdog_ns = 0;

    spi_memory #(
        .SYNC_STAGES (2)
    ) DUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .sclk    (sclk),
        .cs_n    (cs_n),
        .mosi    (mosi),
        .miso    (miso),
        .miso_oe (miso_oe)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic half_period;
        repeat (sclk_half) @(negedge clk);
    endtask

    // mode 0 bits go out msb first and miso is taken just before each rising sclk
    task automatic xfer_bits(input logic [7:0] tx, input logic oe_exp, input int nbits,
                             input string phase, output logic [7:0] rx);
        rx = '0;
        for (int i = 7; i >= 8 - nbits; i--) begin
            mosi = tx[i];
            half_period();
            if (miso_oe !== oe_exp) begin
                $display("mismatch at time %0t: miso_oe during %s, expected %b, got %b",
                         $time, phase, oe_exp, miso_oe);
                test_errors++;
            end
            rx = {rx[6:0], miso};
            sclk = 1'b1;
            half_period();
            sclk = 1'b0;
        end
    endtask

    task automatic end_transfer;
        half_period();
        cs_n = 1'b1;
        mosi = 1'b0;
        half_period();
        if (miso_oe !== 1'b0) begin
            $display("mismatch at time %0t: miso_oe with cs_n high, expected 0, got %b",
                     $time, miso_oe);
            test_errors++;
        end
    endtask

    task automatic spi_write(input logic [6:0] addr, input logic [7:0] data);
        logic [7:0] rx;
        cs_n = 1'b0;
        xfer_bits({addr, 1'b0}, 1'b0, 8, "write address", rx);
        xfer_bits(data, 1'b0, 8, "write data", rx);
        end_transfer();
    endtask

    task automatic spi_read(input logic [6:0] addr, output logic [7:0] data);
        logic [7:0] rx;
        cs_n = 1'b0;
        xfer_bits({addr, 1'b1}, 1'b0, 8, "read address", rx);
        xfer_bits(8'h00, 1'b1, 8, "read data", data);
        end_transfer();
    endtask

    // write that loses cs_n after nbits rising edges
    task automatic spi_abort(input logic [6:0] addr, input logic [7:0] data, input int nbits);
        logic [7:0] rx;
        cs_n = 1'b0;
        if (nbits <= 8) begin
            xfer_bits({addr, 1'b0}, 1'b0, nbits, "aborted address", rx);
        end else begin
            xfer_bits({addr, 1'b0}, 1'b0, 8, "aborted address", rx);
            xfer_bits(data, 1'b0, nbits - 8, "aborted data", rx);
        end
        end_transfer();
    endtask

    task automatic check_read(input logic [6:0] addr, input logic [7:0] expected);
        logic [7:0] got;
        spi_read(addr, got);
        if (got !== expected) begin
            $display("mismatch at time %0t: miso byte from 0x%02h, expected 0x%02h, got 0x%02h",
                     $time, addr, expected, got);
            test_errors++;
        end
    endtask

    task automatic random_burst(input int count);
        logic [6:0] addr;
        logic [6:0] last_addr;
        logic [7:0] data;
        last_addr = '0;
        for (int k = 0; k < count; k++) begin
            rng_state = xorshift32(rng_state);
            addr = rng_state[6:0];
            data = rng_state[15:8];
            if (rng_state[16]) begin
                // half the reads go back to the latest written byte
                if (rng_state[17]) begin
                    addr = last_addr;
                end
                check_read(addr, ref_mem[addr]);
            end else begin
                spi_write(addr, data);
                ref_mem[addr] = data;
                last_addr = addr;
            end
        end
    endtask

    task automatic load_cases;
        int               fd;
        int               code;
        logic [7:0]       op;
        logic [7:0]       a;
        logic [7:0]       d;
        logic [8*160-1:0] skip;
        num_cases = 0;
        fd = $fopen(cases_file, "r");
        if (fd == 0) begin
            $display("cannot open the cases file %0s", cases_file);
            return;
        end
        while (!$feof(fd) && num_cases < max_cases) begin
            code = $fscanf(fd, " %c", op);
            if (code != 1) begin
                break;
            end
            if (op == "#") begin
                code = $fgets(skip, fd);
            end else begin
                code = $fscanf(fd, " %h %h", a, d);
                if (code == 2) begin
                    case_op[num_cases]   = op;
                    case_addr[num_cases] = a;
                    case_data[num_cases] = d;
                    num_cases++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic run_case(input int c);
        logic [7:0] op;
        logic [6:0] addr;
        logic [7:0] data;
        op   = case_op[c];
        addr = case_addr[c][6:0];
        data = case_data[c];
        test_errors = 0;
        case (op)
            "w": begin
                spi_write(addr, data);
                ref_mem[addr] = data;
            end
            "r": begin
                if (ref_mem[addr] !== data) begin
                    $display("case %0d expects 0x%02h at 0x%02h but the model holds 0x%02h",
                             c, data, addr, ref_mem[addr]);
                    test_errors++;
                end
                check_read(addr, data);
            end
            "a": begin
                if (data == 8'd0 || data > 8'd15) begin
                    $display("case %0d has an abort bit count out of range", c);
                    test_errors++;
                end else begin
                    // the byte is inverted so a write that slipped through would show
                    spi_abort(addr, ~ref_mem[addr], int'(data));
                end
            end
            "n": random_burst(int'(data));
            default: begin
                $display("case %0d has an unknown operation '%c'", c, op);
                test_errors++;
            end
        endcase
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0d (%c 0x%02h 0x%02h): ok", c, op, case_addr[c], data);
        end else begin
            $display("test %0d (%c 0x%02h 0x%02h): %0d errors", c, op, case_addr[c], data,
                     test_errors);
            tests_failed++;
        end
        total_errors += test_errors;
    endtask

    initial begin
        wait (watchdog_ns > 0);
        #(watchdog_ns);
        $display("watchdog expired after %0d ns with transactions still running", watchdog_ns);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        longint ops;
        rst_n = 1'b0;
        sclk = 1'b0;
        cs_n = 1'b1;
        mosi = 1'b0;
        rng_state = rng_seed;
        tests_run = 0;
        tests_failed = 0;
        total_errors = 0;
        for (int i = 0; i < 128; i++) begin
            ref_mem[i] = '0;
        end
        load_cases();
        if (num_cases == 0) begin
            $display("no cases were loaded");
            total_errors++;
        end
        // a burst line counts once per operation
        ops = 0;
        for (int c = 0; c < num_cases; c++) begin
            ops += (case_op[c] == "n") ? longint'(case_data[c]) : 64'd1;
        end
        watchdog_ns = (ops + 2) * 40 * sclk_period + 20 * clk_period;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        repeat (4) @(negedge clk);
        for (int c = 0; c < num_cases; c++) begin
            run_case(c);
        end
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
